// ==== Bender.yml ====
package:
  name: memory_interface

sources:
  - include_dirs:
      - include
    files:
      - design/mem_if_pkg.sv
      - design/access_arbiter.sv
      - design/line_store.sv
      - design/io_sequencer.sv
      - design/reply_stage.sv
      - design/memory_interface.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/memory_interface_assert.sv
      - bench/memory_interface_tb.sv

// ==== bench/memory_interface_assert.sv ====
`timescale 1ns/1ps
`include "mem_if_consts.svh"
`default_nettype none

module memory_interface_assert (
	input logic                           main_clk,
	input logic                           rst_n,
	input logic [`MEM_IF_EXEC_PORTS-1:0]  exec_req,
	input logic [`MEM_IF_FETCH_PORTS-1:0] fetch_req,
	input logic [`MEM_IF_EXEC_PORTS-1:0]  exec_ack,
	input logic [`MEM_IF_FETCH_PORTS-1:0] fetch_ack,
	input mem_if_pkg::byte_addr_t         io_addr
);
	int violations = 0;

	exec_ack_one_hot: assert property (@(posedge main_clk) disable iff (!rst_n)
		$onehot0(exec_ack))
		else begin
			$error("more than one executer acknowledged in the same cycle");
			violations++;
		end

	// the bus strobe marks the start of a transaction and must drop after one cycle
	io_strobe_single: assert property (@(posedge main_clk) disable iff (!rst_n)
		io_addr[`MEM_IF_IO_BIT] |=> !io_addr[`MEM_IF_IO_BIT])
		else begin
			$error("io_addr strobe bit stayed high for more than one cycle");
			violations++;
		end

	exec_ack_requested: assert property (@(posedge main_clk) disable iff (!rst_n)
		(exec_ack & ~$past(exec_req)) == '0)
		else begin
			$error("executer acknowledged without an active request");
			violations++;
		end

	fetch_ack_requested: assert property (@(posedge main_clk) disable iff (!rst_n)
		(fetch_ack & ~$past(fetch_req)) == '0)
		else begin
			$error("fetch port acknowledged without an active request");
			violations++;
		end

endmodule

bind memory_interface memory_interface_assert u_memory_interface_assert (
	.main_clk(main_clk),
	.rst_n(rst_n),
	.exec_req(exec_req),
	.fetch_req(fetch_req),
	.exec_ack(exec_ack),
	.fetch_ack(fetch_ack),
	.io_addr(io_addr)
);

`default_nettype wire

// ==== bench/memory_interface_tb.sv ====
`timescale 1ns/1ps
`include "mem_if_consts.svh"
`default_nettype none

module memory_interface_tb;
	import mem_if_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 10;
	localparam int ACK_LIMIT = 20; // cycles one access may take before it counts as lost
	localparam int WORD_TESTS = 16;
	localparam int BYTE_TESTS = 4;
	localparam int FETCH_TESTS = 4;
	localparam int ACCESS_CYCLES = 6;
	localparam int IO_CYCLES = 12;
	localparam int TEST_CYCLES = RESET_CYCLES + 2
		+ ACCESS_CYCLES * (`MEM_IF_STORE_WORDS + 2 * WORD_TESTS + 2 * BYTE_TESTS + FETCH_TESTS)
		+ 4 * ACCESS_CYCLES + 3 * IO_CYCLES;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;

	logic main_clk;
	logic rst_n;
	logic [`MEM_IF_EXEC_PORTS-1:0] exec_req;
	logic [`MEM_IF_EXEC_PORTS-1:0] exec_write;
	logic [`MEM_IF_EXEC_PORTS-1:0] exec_byte;
	byte_addr_t exec_addr [`MEM_IF_EXEC_PORTS];
	data_word_t exec_data [`MEM_IF_EXEC_PORTS];
	logic [`MEM_IF_FETCH_PORTS-1:0] fetch_req;
	word_addr_t fetch_addr [`MEM_IF_FETCH_PORTS];
	logic [`MEM_IF_EXEC_PORTS-1:0] exec_ack;
	logic [`MEM_IF_FETCH_PORTS-1:0] fetch_ack;
	line_data_t exec_line;
	line_data_t fetch_line;
	logic [`MEM_IF_EXEC_PORTS-1:0] dep_clear;
	byte_addr_t io_addr;
	data_word_t io_wdata;
	logic [1:0] io_ctrl;
	data_word_t io_rdata;

	data_word_t model_mem [`MEM_IF_STORE_WORDS]; // reference copy of the line store
	logic [31:0] lcg_state = 32'h89fc_ca73;
	int check_count = 0;
	int error_count = 0;
	int assert_fails;

	// the I/O device keeps what it saw on the bus during the last strobe
	byte_addr_t dev_addr = '0;
	logic [1:0] dev_ctrl = '0;
	data_word_t dev_wdata = '0;
	int dev_strobes = 0;

	memory_interface u_memory_interface (
		.main_clk(main_clk), .rst_n(rst_n),
		.exec_req(exec_req), .exec_write(exec_write), .exec_byte(exec_byte),
		.exec_addr(exec_addr), .exec_data(exec_data),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.exec_ack(exec_ack), .fetch_ack(fetch_ack),
		.exec_line(exec_line), .fetch_line(fetch_line), .dep_clear(dep_clear),
		.io_addr(io_addr), .io_wdata(io_wdata), .io_ctrl(io_ctrl), .io_rdata(io_rdata)
	);

	initial begin
		main_clk = 1'b0;
		forever #(CLK_PERIOD / 2) main_clk = ~main_clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: the run took longer than %0d ns and was stopped", WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

	// the device latches the transaction in the middle of the strobe cycle
	always @(negedge main_clk) begin
		if (io_addr[`MEM_IF_IO_BIT] === 1'b1) begin
			dev_addr <= io_addr;
			dev_ctrl <= io_ctrl;
			dev_wdata <= io_wdata;
			dev_strobes <= dev_strobes + 1;
		end
	end

	assign io_rdata = device_value(dev_addr);

	// a read answer built from every address bit below the strobe bit
	function automatic data_word_t device_value(input byte_addr_t addr);
		return addr[15:0] ^ addr[30:15] ^ 16'h3c5a;
	endfunction

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic line_data_t model_line(input word_addr_t addr);
		line_data_t line;
		word_addr_t base;
		base = addr & ~word_addr_t'(`MEM_IF_LINE_WORDS - 1); // aligned line start
		for (int i = 0; i < `MEM_IF_LINE_WORDS; i++) begin
			line[i*`MEM_IF_WORD_W +: `MEM_IF_WORD_W] = model_mem[base + word_addr_t'(i)];
		end
		return line;
	endfunction

	// outputs have settled and new inputs go out shortly after each rising edge
	task automatic next_cycle();
		@(posedge main_clk);
		#(DRIVE_DELAY);
	endtask

	task automatic compare(input string what, input logic [127:0] expected,
			input logic [127:0] actual);
		check_count++;
		assert (actual === expected) else begin
			$display("MISMATCH %s expected %0h actual %0h", what, expected, actual);
			error_count++;
		end
	endtask

	task automatic exec_access(input string test, input int port, input byte_addr_t addr,
			input logic write, input logic byte_op, input data_word_t data,
			input logic check_dep, output line_data_t line);
		int waited;
		exec_addr[port] = addr;
		exec_data[port] = data;
		exec_write[port] = write;
		exec_byte[port] = byte_op;
		exec_req[port] = 1'b1;
		next_cycle();
		if (check_dep) begin
			compare({test, " dep_clear"}, 8'b1 << port, dep_clear); // first sample edge
		end
		waited = 0;
		while (exec_ack == '0 && waited < ACK_LIMIT) begin
			next_cycle();
			waited++;
		end
		assert (exec_ack != '0) else begin
			$display("%s: executer port %0d got no acknowledge within %0d cycles",
				test, port, ACK_LIMIT);
			error_count++;
		end
		compare({test, " exec_ack"}, 8'b1 << port, exec_ack);
		exec_req[port] = 1'b0;
		next_cycle();
		compare({test, " ack pulse"}, 0, exec_ack);
		line = exec_line; // data trails the ack by one cycle
	endtask

	task automatic fetch_access(input string test, input int port, input word_addr_t addr);
		int waited;
		fetch_addr[port] = addr;
		fetch_req[port] = 1'b1;
		next_cycle();
		waited = 0;
		while (fetch_ack == '0 && waited < ACK_LIMIT) begin
			next_cycle();
			waited++;
		end
		assert (fetch_ack != '0) else begin
			$display("%s: fetch port %0d got no acknowledge within %0d cycles",
				test, port, ACK_LIMIT);
			error_count++;
		end
		compare({test, " fetch_ack"}, 2'b1 << port, fetch_ack);
		compare({test, " fetch_line"}, model_line(addr), fetch_line);
		fetch_req[port] = 1'b0;
		next_cycle();
		compare({test, " ack pulse"}, 0, fetch_ack);
	endtask

	task automatic io_access(input string test, input int port, input byte_addr_t addr,
			input logic write, input logic byte_op, input data_word_t data);
		line_data_t line;
		int strobes_before;
		strobes_before = dev_strobes;
		exec_access(test, port, addr, write, byte_op, data, 1'b1, line);
		compare({test, " strobe count"}, 1, dev_strobes - strobes_before);
		compare({test, " io_addr"}, addr, dev_addr);
		compare({test, " io_ctrl"}, {write, byte_op}, dev_ctrl);
		compare({test, " io_wdata"}, data, dev_wdata);
		if (!write) begin
			compare({test, " exec_line"}, line_data_t'(device_value(addr)), line);
		end
	endtask

	task automatic fill_store();
		line_data_t line;
		data_word_t data;
		for (int w = 0; w < `MEM_IF_STORE_WORDS; w++) begin
			data = data_word_t'(next_random() >> 8) ^ data_word_t'(w);
			exec_access("fill_store", w % `MEM_IF_EXEC_PORTS, byte_addr_t'(w) << 1,
				1'b1, 1'b0, data, 1'b0, line);
			model_mem[w] = data;
		end
	endtask

	task automatic test_word_rw();
		line_data_t line;
		data_word_t data;
		word_addr_t w;
		for (int n = 0; n < WORD_TESTS; n++) begin
			w = word_addr_t'(next_random() >> 12);
			data = data_word_t'(next_random() >> 8);
			exec_access("word_rw write", n % 8, byte_addr_t'(w) << 1, 1'b1, 1'b0, data,
				1'b1, line);
			model_mem[w] = data;
			exec_access("word_rw read", (n + 3) % 8, byte_addr_t'(w) << 1, 1'b0, 1'b0,
				16'h0, 1'b1, line);
			compare("word_rw line", model_line(w), line);
		end
	endtask

	task automatic test_byte_write();
		line_data_t line;
		data_word_t data;
		word_addr_t w;
		logic lane;
		for (int n = 0; n < BYTE_TESTS; n++) begin
			lane = n[0]; // even runs hit the low lane, odd runs the high lane
			w = word_addr_t'(next_random() >> 12);
			data = data_word_t'(next_random() >> 8);
			exec_access("byte_write", 2 + n, (byte_addr_t'(w) << 1) | byte_addr_t'(lane),
				1'b1, 1'b1, data, 1'b0, line);
			if (lane) begin
				model_mem[w][15:8] = data[7:0];
			end else begin
				model_mem[w][7:0] = data[7:0];
			end
			exec_access("byte_write read", 7, byte_addr_t'(w) << 1, 1'b0, 1'b0, 16'h0,
				1'b0, line);
			compare("byte_write line", model_line(w), line);
		end
	endtask

	task automatic test_fetch_read();
		word_addr_t w;
		for (int n = 0; n < FETCH_TESTS; n++) begin
			w = word_addr_t'(next_random() >> 12);
			fetch_access("fetch_read", n % 2, w);
		end
	endtask

	task automatic test_priority();
		int order[$];
		int expected_order[5];
		word_addr_t fetch_word [`MEM_IF_FETCH_PORTS];
		int waited;
		int p;
		expected_order = '{1, 3, 6, 8, 9}; // fetch ports are counted as 8 and 9
		for (int k = 0; k < 3; k++) begin
			p = expected_order[k];
			exec_addr[p] = byte_addr_t'(word_addr_t'(next_random() >> 12)) << 1;
			exec_write[p] = 1'b0;
			exec_byte[p] = 1'b0;
		end
		for (int j = 0; j < `MEM_IF_FETCH_PORTS; j++) begin
			fetch_word[j] = word_addr_t'(next_random() >> 12);
			fetch_addr[j] = fetch_word[j];
		end
		exec_req = 8'b0100_1010;
		fetch_req = 2'b11;
		next_cycle();
		compare("priority dep_clear", 8'b0000_0010, dep_clear);
		waited = 0;
		while (order.size() < 5 && waited < ACK_LIMIT) begin
			next_cycle();
			waited++;
			for (int i = 0; i < `MEM_IF_EXEC_PORTS; i++) begin
				if (exec_ack[i]) begin
					order.push_back(i);
					exec_req[i] = 1'b0;
				end
			end
			for (int j = 0; j < `MEM_IF_FETCH_PORTS; j++) begin
				if (fetch_ack[j]) begin
					order.push_back(8 + j);
					compare("priority fetch_line", model_line(fetch_word[j]), fetch_line);
					fetch_req[j] = 1'b0;
				end
			end
		end
		repeat (3) begin
			next_cycle();
			compare("priority extra ack", 0, {exec_ack, fetch_ack});
		end
		compare("priority ack count", 5, order.size());
		for (int k = 0; k < order.size() && k < 5; k++) begin
			compare("priority order", expected_order[k], order[k]);
		end
		exec_req = '0;
		fetch_req = '0;
	endtask

	task automatic test_io();
		io_access("io_read", 2, 32'h8000_1a2c, 1'b0, 1'b0, 16'h0000);
		io_access("io_write", 5, 32'h8012_0047, 1'b1, 1'b1, data_word_t'(next_random() >> 8));
		io_access("io_read", 0, byte_addr_t'(next_random()) | 32'h8000_0000, 1'b0, 1'b0,
			16'h0000);
	endtask

	initial begin
		rst_n = 1'b0;
		exec_req = '0;
		exec_write = '0;
		exec_byte = '0;
		fetch_req = '0;
		for (int i = 0; i < `MEM_IF_EXEC_PORTS; i++) begin
			exec_addr[i] = '0;
			exec_data[i] = '0;
		end
		for (int j = 0; j < `MEM_IF_FETCH_PORTS; j++) begin
			fetch_addr[j] = '0;
		end
		repeat (RESET_CYCLES) @(posedge main_clk);
		#(DRIVE_DELAY);
		rst_n = 1'b1;
		next_cycle();
		compare("reset", 0, {exec_ack, fetch_ack, dep_clear, io_addr[`MEM_IF_IO_BIT]});
		fill_store();
		test_word_rw();
		test_byte_write();
		test_fetch_read();
		test_priority();
		test_io();
		assert_fails = u_memory_interface.u_memory_interface_assert.violations;
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			check_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/access_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_if_consts.svh"
`default_nettype none

module access_arbiter (
	input  logic                           main_clk,
	input  logic                           rst_n,
	input  logic [`MEM_IF_EXEC_PORTS-1:0]  exec_req,
	input  mem_if_pkg::byte_addr_t         exec_addr [`MEM_IF_EXEC_PORTS],
	input  mem_if_pkg::data_word_t         exec_data [`MEM_IF_EXEC_PORTS],
	input  logic [`MEM_IF_EXEC_PORTS-1:0]  exec_write,
	input  logic [`MEM_IF_EXEC_PORTS-1:0]  exec_byte,
	input  logic [`MEM_IF_FETCH_PORTS-1:0] fetch_req,
	input  mem_if_pkg::word_addr_t         fetch_addr [`MEM_IF_FETCH_PORTS],
	input  logic [`MEM_IF_EXEC_PORTS-1:0]  exec_done,
	input  logic [`MEM_IF_FETCH_PORTS-1:0] fetch_done,
	output mem_if_pkg::mem_req_t           issue,
	output logic [`MEM_IF_EXEC_PORTS-1:0]  io_req,
	output logic [`MEM_IF_EXEC_PORTS-1:0]  dep_clear_mem
);
	import mem_if_pkg::*;

	logic [`MEM_IF_EXEC_PORTS-1:0] exec_io; // address bit 31 per executer
	logic [`MEM_IF_EXEC_PORTS-1:0] exec_pending;
	logic [`MEM_IF_FETCH_PORTS-1:0] fetch_pending;
	logic [`MEM_IF_EXEC_PORTS-1:0] mem_exec;
	logic [`MEM_IF_FETCH_PORTS-1:0] mem_fetch;
	logic [`MEM_IF_EXEC_PORTS-1:0] grant_exec;
	logic [`MEM_IF_FETCH_PORTS-1:0] grant_fetch;
	mem_req_t issue_next;

	always_comb begin
		for (int i = 0; i < `MEM_IF_EXEC_PORTS; i++) begin
			exec_io[i] = exec_addr[i][`MEM_IF_IO_BIT];
		end
	end

	// a port that is already in flight must not be picked again before its ack
	assign mem_exec = exec_req & ~exec_io & ~exec_pending;
	assign mem_fetch = fetch_req & ~fetch_pending;
	assign io_req = exec_req & exec_io & ~exec_pending;

	// executers by ascending index first, fetch 0 and fetch 1 after them
	always_comb begin
		issue_next = '0;
		grant_exec = '0;
		grant_fetch = '0;
		for (int j = `MEM_IF_FETCH_PORTS - 1; j >= 0; j--) begin
			if (mem_fetch[j]) begin
				issue_next = '0;
				issue_next.valid = 1'b1;
				issue_next.is_fetch = 1'b1;
				issue_next.port = exec_id_t'(j);
				issue_next.addr = fetch_addr[j];
				grant_fetch = '0;
				grant_fetch[j] = 1'b1;
			end
		end
		for (int i = `MEM_IF_EXEC_PORTS - 1; i >= 0; i--) begin
			if (mem_exec[i]) begin
				issue_next.valid = 1'b1;
				issue_next.is_fetch = 1'b0;
				issue_next.port = exec_id_t'(i);
				issue_next.addr = word_addr_t'(exec_addr[i] >> 1); // byte to word address
				issue_next.write = exec_write[i];
				issue_next.byte_op = exec_byte[i];
				issue_next.byte_hi = exec_addr[i][0];
				issue_next.data = exec_data[i];
				grant_exec = '0;
				grant_exec[i] = 1'b1;
				grant_fetch = '0;
			end
		end
	end

	always_ff @(posedge main_clk) begin
		if (!rst_n) begin
			issue <= '0;
			exec_pending <= '0;
			fetch_pending <= '0;
			dep_clear_mem <= '0;
		end else begin
			issue <= issue_next;
			exec_pending <= (exec_pending & ~exec_done) | grant_exec;
			fetch_pending <= (fetch_pending & ~fetch_done) | grant_fetch;
			dep_clear_mem <= grant_exec; // one-cycle pulse after the grant edge
		end
	end

endmodule

`default_nettype wire

// ==== design/io_sequencer.sv ====
`timescale 1ns/1ps
`include "mem_if_consts.svh"
`default_nettype none

module io_sequencer (
	input  logic                          main_clk,
	input  logic                          rst_n,
	input  logic [`MEM_IF_EXEC_PORTS-1:0] io_req,
	input  mem_if_pkg::byte_addr_t        exec_addr [`MEM_IF_EXEC_PORTS],
	input  mem_if_pkg::data_word_t        exec_data [`MEM_IF_EXEC_PORTS],
	input  logic [`MEM_IF_EXEC_PORTS-1:0] exec_write,
	input  logic [`MEM_IF_EXEC_PORTS-1:0] exec_byte,
	input  mem_if_pkg::data_word_t        io_rdata,
	input  logic                          io_stall,
	output mem_if_pkg::byte_addr_t        io_addr,
	output mem_if_pkg::data_word_t        io_wdata,
	output logic [1:0]                    io_ctrl,
	output logic                          io_done,
	output mem_if_pkg::exec_id_t          io_done_port,
	output mem_if_pkg::data_word_t        io_read_data,
	output logic [`MEM_IF_EXEC_PORTS-1:0] dep_clear_io
);
	import mem_if_pkg::*;

	io_state_e state;
	exec_id_t pick_port;
	exec_id_t io_port;
	logic io_strobe; // bit 31 of the bus address, high for one cycle
	logic [`MEM_IF_IO_BIT-1:0] addr_low;
	logic [3:0] wait_cnt;

	always_comb begin
		pick_port = '0;
		for (int i = `MEM_IF_EXEC_PORTS - 1; i >= 0; i--) begin
			if (io_req[i]) pick_port = exec_id_t'(i); // lowest index ends up last
		end
	end

	always_ff @(posedge main_clk) begin
		if (!rst_n) begin
			state <= IO_IDLE;
			io_strobe <= 1'b0;
			dep_clear_io <= '0;
		end else begin
			dep_clear_io <= '0;
			case (state)
				IO_IDLE: if (|io_req) begin
					state <= IO_DRIVE;
					dep_clear_io[pick_port] <= 1'b1;
				end
				IO_DRIVE: begin
					io_strobe <= 1'b1;
					state <= IO_RELEASE;
				end
				IO_RELEASE: begin
					io_strobe <= 1'b0;
					state <= IO_WAIT;
				end
				IO_WAIT: if (wait_cnt == '0) state <= IO_CAPTURE;
				IO_CAPTURE: state <= IO_RESPOND;
				// writes wait here as well, so an I/O ack never collides with a memory ack
				IO_RESPOND: if (!io_stall) state <= IO_FINISH;
				IO_FINISH: state <= IO_IDLE; // lets the executer drop its request first
				default: state <= IO_IDLE;
			endcase
		end
	end

	always_ff @(posedge main_clk) begin
		case (state)
			IO_IDLE: io_port <= pick_port;
			IO_DRIVE: begin
				addr_low <= exec_addr[io_port][`MEM_IF_IO_BIT-1:0];
				io_wdata <= exec_data[io_port];
				io_ctrl <= {exec_write[io_port], exec_byte[io_port]};
			end
			IO_RELEASE: wait_cnt <= 4'(`MEM_IF_IO_WAIT - 2);
			IO_WAIT: wait_cnt <= wait_cnt - 1'b1;
			IO_CAPTURE: io_read_data <= io_rdata;
			default: ;
		endcase
	end

	assign io_addr = {io_strobe, addr_low};
	assign io_done = (state == IO_RESPOND) && !io_stall;
	assign io_done_port = io_port;

endmodule

`default_nettype wire

// ==== design/line_store.sv ====
`timescale 1ns/1ps
`include "mem_if_consts.svh"
`default_nettype none

module line_store (
	input  logic                   main_clk,
	input  logic                   rst_n,
	input  mem_if_pkg::mem_req_t   issue,
	output mem_if_pkg::mem_reply_t reply
);
	import mem_if_pkg::*;

	localparam int LINES = `MEM_IF_STORE_WORDS / `MEM_IF_LINE_WORDS;
	localparam int WORD_BITS = $clog2(`MEM_IF_LINE_WORDS);
	localparam int WORD_W = `MEM_IF_WORD_W;
	localparam int BYTE_W = `MEM_IF_WORD_W / 2;

	line_data_t store [LINES];
	logic [$clog2(LINES)-1:0] line_idx;
	logic [WORD_BITS-1:0] word_idx;
	logic reply_valid;
	logic reply_fetch;
	exec_id_t reply_port;
	line_data_t reply_line;

	assign word_idx = issue.addr[WORD_BITS-1:0];
	assign line_idx = issue.addr[$bits(word_addr_t)-1:WORD_BITS];

	always_ff @(posedge main_clk) begin
		if (issue.valid && issue.write) begin
			// a byte write always takes its byte from the low half of the data word
			if (!issue.byte_op) begin
				store[line_idx][word_idx*WORD_W +: WORD_W] <= issue.data;
			end else if (issue.byte_hi) begin
				store[line_idx][word_idx*WORD_W + BYTE_W +: BYTE_W] <= issue.data[BYTE_W-1:0];
			end else begin
				store[line_idx][word_idx*WORD_W +: BYTE_W] <= issue.data[BYTE_W-1:0];
			end
		end
		reply_line <= store[line_idx]; // a write returns the line as it was before
		reply_fetch <= issue.is_fetch;
		reply_port <= issue.port;
	end

	always_ff @(posedge main_clk) begin
		if (!rst_n) begin
			reply_valid <= 1'b0;
		end else begin
			reply_valid <= issue.valid;
		end
	end

	assign reply = '{
		valid: reply_valid,
		is_fetch: reply_fetch,
		port: reply_port,
		line: reply_line
	};

endmodule

`default_nettype wire

// ==== design/mem_if_pkg.sv ====
`include "mem_if_consts.svh"
`default_nettype none

package mem_if_pkg;

	typedef logic [$clog2(`MEM_IF_EXEC_PORTS)-1:0] exec_id_t;
	typedef logic [`MEM_IF_WORD_W-1:0] data_word_t;
	typedef logic [`MEM_IF_IO_BIT:0] byte_addr_t; // executer byte address, I/O bit on top
	typedef logic [$clog2(`MEM_IF_STORE_WORDS)-1:0] word_addr_t;
	typedef logic [`MEM_IF_LINE_WORDS*`MEM_IF_WORD_W-1:0] line_data_t; // word 0 in the low bits

	// one request as issued to the line store
	typedef struct packed {
		logic       valid;
		logic       is_fetch;
		exec_id_t   port; // fetches use 0 or 1
		word_addr_t addr;
		logic       write;
		logic       byte_op;
		logic       byte_hi; // upper byte lane of the word
		data_word_t data;
	} mem_req_t;

	typedef struct packed {
		logic       valid;
		logic       is_fetch;
		exec_id_t   port;
		line_data_t line;
	} mem_reply_t;

	typedef enum logic [2:0] {
		IO_IDLE, IO_DRIVE, IO_RELEASE, IO_WAIT, IO_CAPTURE, IO_RESPOND, IO_FINISH
	} io_state_e;

endpackage

`default_nettype wire

// ==== design/memory_interface.sv ====
`timescale 1ns/1ps
`include "mem_if_consts.svh"
`default_nettype none

module memory_interface (
	input  logic                           main_clk,
	input  logic                           rst_n,
	input  logic [`MEM_IF_EXEC_PORTS-1:0]  exec_req,
	input  logic [`MEM_IF_EXEC_PORTS-1:0]  exec_write,
	input  logic [`MEM_IF_EXEC_PORTS-1:0]  exec_byte,
	input  mem_if_pkg::byte_addr_t         exec_addr [`MEM_IF_EXEC_PORTS],
	input  mem_if_pkg::data_word_t         exec_data [`MEM_IF_EXEC_PORTS],
	input  logic [`MEM_IF_FETCH_PORTS-1:0] fetch_req,
	input  mem_if_pkg::word_addr_t         fetch_addr [`MEM_IF_FETCH_PORTS],
	output logic [`MEM_IF_EXEC_PORTS-1:0]  exec_ack,
	output logic [`MEM_IF_FETCH_PORTS-1:0] fetch_ack,
	output mem_if_pkg::line_data_t         exec_line,
	output mem_if_pkg::line_data_t         fetch_line,
	output logic [`MEM_IF_EXEC_PORTS-1:0]  dep_clear,
	output mem_if_pkg::byte_addr_t         io_addr,
	output mem_if_pkg::data_word_t         io_wdata,
	output logic [1:0]                     io_ctrl, // bit 1 write, bit 0 byte
	input  mem_if_pkg::data_word_t         io_rdata
);
	import mem_if_pkg::*;

	mem_req_t issue;
	mem_reply_t reply;
	logic [`MEM_IF_EXEC_PORTS-1:0] io_req;
	logic [`MEM_IF_EXEC_PORTS-1:0] dep_clear_mem;
	logic [`MEM_IF_EXEC_PORTS-1:0] dep_clear_io;
	logic io_done;
	logic io_stall;
	exec_id_t io_done_port;
	data_word_t io_read_data;

	access_arbiter u_access_arbiter (
		.main_clk(main_clk), .rst_n(rst_n),
		.exec_req(exec_req), .exec_addr(exec_addr), .exec_data(exec_data),
		.exec_write(exec_write), .exec_byte(exec_byte),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.exec_done(exec_ack), .fetch_done(fetch_ack),
		.issue(issue), .io_req(io_req), .dep_clear_mem(dep_clear_mem)
	);

	line_store u_line_store (
		.main_clk(main_clk), .rst_n(rst_n), .issue(issue), .reply(reply)
	);

	io_sequencer u_io_sequencer (
		.main_clk(main_clk), .rst_n(rst_n), .io_req(io_req),
		.exec_addr(exec_addr), .exec_data(exec_data),
		.exec_write(exec_write), .exec_byte(exec_byte),
		.io_rdata(io_rdata), .io_stall(io_stall),
		.io_addr(io_addr), .io_wdata(io_wdata), .io_ctrl(io_ctrl),
		.io_done(io_done), .io_done_port(io_done_port),
		.io_read_data(io_read_data), .dep_clear_io(dep_clear_io)
	);

	reply_stage u_reply_stage (
		.main_clk(main_clk), .rst_n(rst_n), .reply(reply),
		.io_done(io_done), .io_done_port(io_done_port), .io_read_data(io_read_data),
		.exec_ack(exec_ack), .fetch_ack(fetch_ack),
		.fetch_line(fetch_line), .exec_line(exec_line), .io_stall(io_stall)
	);

	// memory and I/O grants never fall on the same executer in one cycle
	assign dep_clear = dep_clear_mem | dep_clear_io;

endmodule

`default_nettype wire

// ==== design/reply_stage.sv ====
`timescale 1ns/1ps
`include "mem_if_consts.svh"
`default_nettype none

module reply_stage (
	input  logic                           main_clk,
	input  logic                           rst_n,
	input  mem_if_pkg::mem_reply_t         reply,
	input  logic                           io_done,
	input  mem_if_pkg::exec_id_t           io_done_port,
	input  mem_if_pkg::data_word_t         io_read_data,
	output logic [`MEM_IF_EXEC_PORTS-1:0]  exec_ack,
	output logic [`MEM_IF_FETCH_PORTS-1:0] fetch_ack,
	output mem_if_pkg::line_data_t         fetch_line,
	output mem_if_pkg::line_data_t         exec_line,
	output logic                           io_stall
);
	import mem_if_pkg::*;

	logic [`MEM_IF_EXEC_PORTS-1:0] exec_next;
	logic [`MEM_IF_FETCH_PORTS-1:0] fetch_next;
	line_data_t line_q;
	logic mem_line_q; // an executer memory result sits in line_q
	logic io_line_q; // an I/O completion was just acknowledged

	// the sequencer holds its response while an executer line is on its way
	assign io_stall = reply.valid && !reply.is_fetch;

	always_comb begin
		exec_next = '0;
		fetch_next = '0;
		if (reply.valid && reply.is_fetch) fetch_next[reply.port[0]] = 1'b1;
		if (io_stall) exec_next[reply.port] = 1'b1;
		if (io_done) exec_next[io_done_port] = 1'b1;
	end

	always_ff @(posedge main_clk) begin
		if (!rst_n) begin
			exec_ack <= '0;
			fetch_ack <= '0;
			mem_line_q <= 1'b0;
			io_line_q <= 1'b0;
		end else begin
			exec_ack <= exec_next;
			fetch_ack <= fetch_next;
			mem_line_q <= io_stall;
			io_line_q <= io_done;
		end
	end

	always_ff @(posedge main_clk) begin
		line_q <= reply.line;
		// executer data lands one cycle behind its ack and holds until the next result
		if (mem_line_q) begin
			exec_line <= line_q;
		end else if (io_line_q) begin
			exec_line <= line_data_t'(io_read_data);
		end
	end

	assign fetch_line = line_q; // same cycle as fetch_ack

endmodule

`default_nettype wire

// ==== include/mem_if_consts.svh ====
`ifndef MEM_IF_CONSTS_SVH
`define MEM_IF_CONSTS_SVH

`default_nettype none

// port counts on the request side
`define MEM_IF_EXEC_PORTS 8
`define MEM_IF_FETCH_PORTS 2

`define MEM_IF_WORD_W 16 // one data word
`define MEM_IF_LINE_WORDS 8 // words per cache line
`define MEM_IF_STORE_WORDS 256 // depth of the on-chip line store

// the top address bit marks an I/O access and doubles as the bus start strobe
`define MEM_IF_IO_BIT 31
`define MEM_IF_IO_WAIT 2 // bus cycles between strobe fall and data sample

`default_nettype wire

`endif

// ==== list.f ====
+incdir+include
design/mem_if_pkg.sv
design/access_arbiter.sv
design/line_store.sv
design/io_sequencer.sv
design/reply_stage.sv
design/memory_interface.sv
bench/memory_interface_assert.sv
bench/memory_interface_tb.sv
